/* hdl/dcache_cfg_pkg.sv */
//////////////////////////////////////////////////
// dcache configuration
// geometry of the L1 data cache memory core and
// the vector types derived from it
//////////////////////////////////////////////////

package dcache_cfg_pkg;

  // geometry
  localparam int unsigned NumWays    = 2;
  localparam int unsigned NumSets    = 16;
  localparam int unsigned NumBanks   = 4;
  localparam int unsigned NumRdPorts = 2;
  localparam int unsigned WordBytes  = 4;
  localparam int unsigned TagWidth   = 8;

  // derived widths
  localparam int unsigned WordWidth    = WordBytes * 8;
  localparam int unsigned LineWidth    = NumBanks * WordWidth;
  localparam int unsigned IdxWidth     = $clog2(NumSets);
  localparam int unsigned OffWidth     = $clog2(NumBanks);
  localparam int unsigned PortIdxWidth = $clog2(NumRdPorts);

  typedef logic [TagWidth-1:0]     tag_t;
  typedef logic [IdxWidth-1:0]     idx_t;
  // word offset, equal to the bank number
  typedef logic [OffWidth-1:0]     off_t;
  typedef logic [WordWidth-1:0]    word_t;
  typedef logic [WordBytes-1:0]    be_t;
  typedef logic [NumWays-1:0]      way_vec_t;
  typedef logic [LineWidth-1:0]    line_t;
  typedef logic [NumRdPorts-1:0]   port_vec_t;
  typedef logic [PortIdxWidth-1:0] port_idx_t;

endpackage

/* hdl/dcache_if_pkg.sv */
//////////////////////////////////////////////////
// dcache interface types
// request, fill, word write and lookup command
// bundles exchanged inside the memory core
//////////////////////////////////////////////////

package dcache_if_pkg;

  import dcache_cfg_pkg::*;

  // one read port, tag follows a cycle later
  typedef struct packed {
    logic req;
    logic prio;
    idx_t idx;
    off_t off;
  } rd_req_t;

  // full line fill with tag and valid bits
  typedef struct packed {
    logic     vld;
    way_vec_t way_we;
    way_vec_t vld_bits;
    tag_t     tag;
    idx_t     idx;
    line_t    data;
  } fill_t;

  // single word write, req selects the ways
  typedef struct packed {
    way_vec_t req;
    idx_t     idx;
    off_t     off;
    word_t    data;
    be_t      be;
  } word_wr_t;

  // granted lookup from the arbiter
  typedef struct packed {
    logic      lookup;
    port_idx_t port;
    idx_t      idx;
    off_t      off;
  } lookup_cmd_t;

endpackage

/* hdl/dcache_port_arbiter.sv */
//////////////////////////////////////////////////
// dcache port arbiter
// priority then round-robin read arbitration,
// fill blocking and word write bank collisions
//////////////////////////////////////////////////

module dcache_port_arbiter
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rd_req_t [NumRdPorts-1:0] rd_req_i,
  input  fill_t                    fill_i,
  input  word_wr_t                 word_wr_i,
  output port_vec_t                rd_ack_o,
  output logic                     wr_ack_o,
  output lookup_cmd_t              cmd_o,
  output logic [NumBanks-1:0]      bank_req_o,
  output logic [NumBanks-1:0]      bank_we_o,
  output idx_t [NumBanks-1:0]      bank_idx_o
);

  port_vec_t req, prio_req, req_masked;
  port_idx_t rr_q, gnt_idx;
  logic      rd_gnt;
  off_t      rd_off;

  //////////////////////////////////////////////////
  // read arbitration
  //////////////////////////////////////////////////

  always_comb begin : p_req
    for (int p = 0; p < NumRdPorts; p++) begin
      req[p]      = rd_req_i[p].req;
      prio_req[p] = rd_req_i[p].req & rd_req_i[p].prio;
    end
  end

  // any high prio request masks the low prio ones
  assign req_masked = (|prio_req) ? prio_req : req;

  // first requester at or after the pointer
  always_comb begin : p_rr
    port_idx_t cand;
    logic      found;
    gnt_idx = rr_q;
    found   = 1'b0;
    for (int i = 0; i < NumRdPorts; i++) begin
      cand = port_idx_t'((int'(rr_q) + i) % NumRdPorts);
      if (!found && req_masked[cand]) begin
        gnt_idx = cand;
        found   = 1'b1;
      end
    end
  end

  assign rd_gnt = (|req_masked) & ~fill_i.vld;
  assign rd_off = rd_req_i[gnt_idx].off;

  always_comb begin : p_ack
    for (int p = 0; p < NumRdPorts; p++) begin
      rd_ack_o[p] = rd_gnt & (gnt_idx == port_idx_t'(p));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_gnt) begin
      rr_q <= port_idx_t'((int'(gnt_idx) + 1) % NumRdPorts);
    end
  end

  assign cmd_o.lookup = rd_gnt;
  assign cmd_o.port   = gnt_idx;
  assign cmd_o.idx    = rd_req_i[gnt_idx].idx;
  assign cmd_o.off    = rd_off;

  //////////////////////////////////////////////////
  // bank requests
  //////////////////////////////////////////////////

  // word write loses only against a read of the same bank
  assign wr_ack_o = (|word_wr_i.req) & ~fill_i.vld &
                    ~(rd_gnt & (rd_off == word_wr_i.off));

  always_comb begin : p_bank
    bank_req_o = '0;
    bank_we_o  = '0;
    bank_idx_o = {NumBanks{word_wr_i.idx}};
    if (fill_i.vld) begin
      bank_req_o = '1;
      bank_we_o  = '1;
      bank_idx_o = {NumBanks{fill_i.idx}};
    end else begin
      if (rd_gnt) begin
        bank_req_o[rd_off] = 1'b1;
        bank_idx_o[rd_off] = cmd_o.idx;
      end
      if (wr_ack_o) begin
        bank_req_o[word_wr_i.off] = 1'b1;
        bank_we_o[word_wr_i.off]  = 1'b1;
      end
    end
  end

endmodule

/* hdl/dcache_tag_lookup.sv */
//////////////////////////////////////////////////
// dcache tag lookup
// per-way tag array and valid flops, compares the
// late tag against the set read a cycle earlier
//////////////////////////////////////////////////

module dcache_tag_lookup
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lookup_cmd_t           cmd_i,
  input  fill_t                 fill_i,
  input  tag_t [NumRdPorts-1:0] rd_tag_i,
  output way_vec_t              hit_o,
  output way_vec_t              vld_bits_o
);

  way_vec_t [NumSets-1:0] vld_q;
  way_vec_t               vld_rd_q;
  logic                   cmp_en_q;
  port_idx_t              port_q;
  tag_t                   rd_tag;

  // valid bits live in flops so the cache starts empty
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld
    if (!rst_ni) begin
      vld_q <= '0;
    end else if (fill_i.vld) begin
      for (int w = 0; w < NumWays; w++) begin
        if (fill_i.way_we[w]) begin
          vld_q[fill_i.idx][w] <= fill_i.vld_bits[w];
        end
      end
    end
  end

  // lookup state for the compare cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cmp
    if (!rst_ni) begin
      cmp_en_q <= 1'b0;
      port_q   <= '0;
      vld_rd_q <= '0;
    end else begin
      cmp_en_q <= cmd_i.lookup;
      vld_rd_q <= cmd_i.lookup ? vld_q[cmd_i.idx] : '0;
      if (cmd_i.lookup) begin
        port_q <= cmd_i.port;
      end
    end
  end

  // tag arrives one cycle after the request
  assign rd_tag     = rd_tag_i[port_q];
  assign vld_bits_o = vld_rd_q;

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    tag_t tag_mem [NumSets];
    tag_t tag_rd_q;

    always_ff @(posedge clk_i) begin : p_tag_mem
      if (fill_i.vld && fill_i.way_we[w]) begin
        tag_mem[fill_i.idx] <= fill_i.tag;
      end
      if (cmd_i.lookup) begin
        tag_rd_q <= tag_mem[cmd_i.idx];
      end
    end

    assign hit_o[w] = cmp_en_q & vld_rd_q[w] & (tag_rd_q == rd_tag);
  end

endmodule

/* hdl/dcache_data_banks.sv */
//////////////////////////////////////////////////
// dcache data banks
// one word bank per line offset, each holding all
// ways, with byte writes and synchronous read
//////////////////////////////////////////////////

module dcache_data_banks
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [NumBanks-1:0]                 bank_req_i,
  input  logic [NumBanks-1:0]                 bank_we_i,
  input  idx_t [NumBanks-1:0]                 bank_idx_i,
  input  fill_t                               fill_i,
  input  word_wr_t                            word_wr_i,
  output word_t [NumBanks-1:0][NumWays-1:0]   bank_rdata_o
);

  // bank b holds word b of every line
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    for (genvar w = 0; w < NumWays; w++) begin : gen_way
      word_t mem_q [NumSets];
      word_t wdata;
      word_t rdata_q;
      be_t   wbe;

      // fills write whole words, word writes use their byte enables
      always_comb begin : p_wsel
        if (fill_i.vld) begin
          wdata = fill_i.data[b*WordWidth +: WordWidth];
          wbe   = {WordBytes{fill_i.way_we[w]}};
        end else begin
          wdata = word_wr_i.data;
          wbe   = word_wr_i.req[w] ? word_wr_i.be : '0;
        end
      end

      always_ff @(posedge clk_i) begin : p_write
        if (bank_req_i[b] && bank_we_i[b]) begin
          for (int k = 0; k < WordBytes; k++) begin
            if (wbe[k]) begin
              mem_q[bank_idx_i[b]][8*k +: 8] <= wdata[8*k +: 8];
            end
          end
        end
      end

      always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
        if (!rst_ni) begin
          rdata_q <= '0;
        end else if (bank_req_i[b] && !bank_we_i[b]) begin
          rdata_q <= mem_q[bank_idx_i[b]];
        end
      end

      assign bank_rdata_o[b][w] = rdata_q;
    end
  end

endmodule

/* hdl/dcache_readout.sv */
//////////////////////////////////////////////////
// dcache readout
// picks the word of the lowest hitting way from
// the bank of the looked up offset
//////////////////////////////////////////////////

module dcache_readout
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  lookup_cmd_t                       cmd_i,
  input  way_vec_t                          hit_i,
  input  word_t [NumBanks-1:0][NumWays-1:0] bank_rdata_i,
  output word_t                             rd_data_o
);

  off_t                 off_q;
  word_t [NumWays-1:0]  way_data;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_off
    if (!rst_ni) begin
      off_q <= '0;
    end else if (cmd_i.lookup) begin
      off_q <= cmd_i.off;
    end
  end

  assign way_data = bank_rdata_i[off_q];

  // walk down so the lowest hitting way wins, zero on a miss
  always_comb begin : p_sel
    rd_data_o = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (hit_i[w]) begin
        rd_data_o = way_data[w];
      end
    end
  end

endmodule

/* hdl/dcache_mem_top.sv */
//////////////////////////////////////////////////
// dcache memory core
// arbiter, tag lookup, data banks and readout of
// the write-through L1 data cache
//////////////////////////////////////////////////

module dcache_mem_top
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rd_req_t [NumRdPorts-1:0] rd_req_i,
  input  tag_t [NumRdPorts-1:0]    rd_tag_i,
  input  fill_t                    fill_i,
  input  word_wr_t                 word_wr_i,
  output port_vec_t                rd_ack_o,
  output logic                     wr_ack_o,
  output way_vec_t                 rd_hit_o,
  output way_vec_t                 rd_vld_bits_o,
  output word_t                    rd_data_o
);

  lookup_cmd_t                       cmd;
  logic [NumBanks-1:0]               bank_req;
  logic [NumBanks-1:0]               bank_we;
  idx_t [NumBanks-1:0]               bank_idx;
  word_t [NumBanks-1:0][NumWays-1:0] bank_rdata;

  dcache_port_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_req_i   (rd_req_i),
    .fill_i     (fill_i),
    .word_wr_i  (word_wr_i),
    .rd_ack_o   (rd_ack_o),
    .wr_ack_o   (wr_ack_o),
    .cmd_o      (cmd),
    .bank_req_o (bank_req),
    .bank_we_o  (bank_we),
    .bank_idx_o (bank_idx)
  );

  dcache_tag_lookup u_tag_lookup (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd_i      (cmd),
    .fill_i     (fill_i),
    .rd_tag_i   (rd_tag_i),
    .hit_o      (rd_hit_o),
    .vld_bits_o (rd_vld_bits_o)
  );

  dcache_data_banks u_data_banks (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bank_req_i   (bank_req),
    .bank_we_i    (bank_we),
    .bank_idx_i   (bank_idx),
    .fill_i       (fill_i),
    .word_wr_i    (word_wr_i),
    .bank_rdata_o (bank_rdata)
  );

  dcache_readout u_readout (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd),
    .hit_i        (rd_hit_o),
    .bank_rdata_i (bank_rdata),
    .rd_data_o    (rd_data_o)
  );

endmodule

/* bench/dcache_mem_asserts.sv */
//////////////////////////////////////////////////
// dcache memory core checker
// shadow model of tags, valid bits and words with
// assertions on grants and read results
//////////////////////////////////////////////////

module dcache_mem_asserts
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;
(
  input logic                     clk_i,
  input logic                     rst_ni,
  input rd_req_t [NumRdPorts-1:0] rd_req_i,
  input tag_t [NumRdPorts-1:0]    rd_tag_i,
  input fill_t                    fill_i,
  input word_wr_t                 word_wr_i,
  input port_vec_t                rd_ack_o,
  input logic                     wr_ack_o,
  input way_vec_t                 rd_hit_o,
  input way_vec_t                 rd_vld_bits_o,
  input word_t                    rd_data_o
);

  tag_t        tag_sh [NumWays][NumSets];
  way_vec_t    vld_sh [NumSets];
  word_t       mem_sh [NumWays][NumSets][NumBanks];
  logic        ack_q;
  port_idx_t   port_q;
  port_idx_t   last_q;
  way_vec_t    exp_vld_q;
  way_vec_t    exp_hit;
  tag_t        exp_tag_q [NumWays];
  word_t       exp_word_q [NumWays];
  port_vec_t   exp_ack;
  logic        exp_wr_ack;
  word_t       exp_data;
  int unsigned err_cnt = 0;

  //////////////////////////////////////////////////
  // expected grants
  //////////////////////////////////////////////////

  always_comb begin : p_exp_gnt
    port_vec_t hi;
    port_vec_t rq;
    port_vec_t msk;
    off_t      gnt_off;
    for (int p = 0; p < NumRdPorts; p++) begin
      rq[p] = rd_req_i[p].req;
      hi[p] = rd_req_i[p].req & rd_req_i[p].prio;
    end
    msk     = (|hi) ? hi : rq;
    exp_ack = '0;
    if (!fill_i.vld && (|msk)) begin
      // both ports compete, the one after the last grant wins
      if (&msk) begin
        exp_ack[port_idx_t'((int'(last_q) + 1) % NumRdPorts)] = 1'b1;
      end else begin
        exp_ack = msk;
      end
    end
    gnt_off = '0;
    for (int p = 0; p < NumRdPorts; p++) begin
      if (exp_ack[p]) begin
        gnt_off = rd_req_i[p].off;
      end
    end
    exp_wr_ack = (|word_wr_i.req) && !fill_i.vld && !((|exp_ack) && gnt_off == word_wr_i.off);
  end

  // result of the read taken one cycle earlier
  always_comb begin : p_exp_res
    for (int w = 0; w < NumWays; w++) begin
      exp_hit[w] = exp_vld_q[w] & (exp_tag_q[w] == rd_tag_i[port_q]);
    end
    exp_data = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (exp_hit[w]) begin
        exp_data = exp_word_q[w];
      end
    end
  end

  //////////////////////////////////////////////////
  // shadow model
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_shadow_ctl
    if (!rst_ni) begin
      for (int s = 0; s < NumSets; s++) begin
        vld_sh[s] <= '0;
      end
      ack_q     <= 1'b0;
      port_q    <= '0;
      last_q    <= port_idx_t'(NumRdPorts - 1);
      exp_vld_q <= '0;
    end else begin
      ack_q <= |rd_ack_o;
      for (int p = 0; p < NumRdPorts; p++) begin
        if (rd_ack_o[p]) begin
          port_q    <= port_idx_t'(p);
          last_q    <= port_idx_t'(p);
          exp_vld_q <= vld_sh[rd_req_i[p].idx];
        end
      end
      if (fill_i.vld) begin
        for (int w = 0; w < NumWays; w++) begin
          if (fill_i.way_we[w]) begin
            vld_sh[fill_i.idx][w] <= fill_i.vld_bits[w];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_shadow_mem
    for (int p = 0; p < NumRdPorts; p++) begin
      if (rd_ack_o[p]) begin
        for (int w = 0; w < NumWays; w++) begin
          exp_tag_q[w]  <= tag_sh[w][rd_req_i[p].idx];
          exp_word_q[w] <= mem_sh[w][rd_req_i[p].idx][rd_req_i[p].off];
        end
      end
    end
    for (int w = 0; w < NumWays; w++) begin
      if (fill_i.vld && fill_i.way_we[w]) begin
        tag_sh[w][fill_i.idx] <= fill_i.tag;
        for (int b = 0; b < NumBanks; b++) begin
          mem_sh[w][fill_i.idx][b] <= fill_i.data[b*WordWidth +: WordWidth];
        end
      end
      if (wr_ack_o && word_wr_i.req[w]) begin
        for (int k = 0; k < WordBytes; k++) begin
          if (word_wr_i.be[k]) begin
            mem_sh[w][word_wr_i.idx][word_wr_i.off][8*k +: 8] <= word_wr_i.data[8*k +: 8];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  a_rd_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) rd_ack_o == exp_ack)
    else begin
      err_cnt++;
      $error("FAILED rd_ack expected %b actual %b", exp_ack, rd_ack_o);
    end

  a_wr_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) wr_ack_o == exp_wr_ack)
    else begin
      err_cnt++;
      $error("FAILED wr_ack expected %b actual %b", exp_wr_ack, wr_ack_o);
    end

  a_fill_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_i.vld |-> (rd_ack_o == '0) && !wr_ack_o)
    else begin
      err_cnt++;
      $error("read or write acknowledged during a line fill");
    end

  a_idle_res: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !ack_q |-> (rd_hit_o == '0) && (rd_vld_bits_o == '0))
    else begin
      err_cnt++;
      $error("hit or valid bits raised without a read in flight");
    end

  a_hit: assert property (@(posedge clk_i) disable iff (!rst_ni) ack_q |-> rd_hit_o == exp_hit)
    else begin
      err_cnt++;
      $error("FAILED rd_hit expected %b actual %b", exp_hit, rd_hit_o);
    end

  a_vld: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_q |-> rd_vld_bits_o == exp_vld_q)
    else begin
      err_cnt++;
      $error("FAILED rd_vld_bits expected %b actual %b", exp_vld_q, rd_vld_bits_o);
    end

  a_data: assert property (@(posedge clk_i) disable iff (!rst_ni) ack_q |-> rd_data_o == exp_data)
    else begin
      err_cnt++;
      $error("FAILED rd_data expected %h actual %h", exp_data, rd_data_o);
    end

endmodule

/* bench/tb_dcache_mem.sv */
//////////////////////////////////////////////////
// dcache memory core testbench
// drives reads, fills and word writes, the bound
// checker compares the responses
//////////////////////////////////////////////////

module tb_dcache_mem
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;
();

  localparam int WaitLimit = 50;

  logic                     clk;
  logic                     rst_n;
  rd_req_t [NumRdPorts-1:0] rd_req;
  tag_t [NumRdPorts-1:0]    rd_tag;
  fill_t                    fill;
  word_wr_t                 word_wr;
  port_vec_t                rd_ack;
  logic                     wr_ack;
  way_vec_t                 rd_hit;
  way_vec_t                 rd_vld_bits;
  word_t                    rd_data;
  logic [15:0]              lfsr_q;
  int unsigned              timeouts;
  int unsigned              n_tests;
  int unsigned              fail_mark;

  dcache_mem_top dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .rd_req_i      (rd_req),
    .rd_tag_i      (rd_tag),
    .fill_i        (fill),
    .word_wr_i     (word_wr),
    .rd_ack_o      (rd_ack),
    .wr_ack_o      (wr_ack),
    .rd_hit_o      (rd_hit),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_data_o     (rd_data)
  );

  bind dcache_mem_top dcache_mem_asserts u_asserts (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_tag_i      (rd_tag_i),
    .fill_i        (fill_i),
    .word_wr_i     (word_wr_i),
    .rd_ack_o      (rd_ack_o),
    .wr_ack_o      (wr_ack_o),
    .rd_hit_o      (rd_hit_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] step_lfsr(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = step_lfsr(lfsr_q);
      v[i]   = lfsr_q[0];
    end
  endtask

  task automatic wait_read_ack(input port_vec_t mask);
    logic got;
    got = 1'b0;
    for (int t = 0; t < WaitLimit && !got; t++) begin
      @(negedge clk);
      got = |(rd_ack & mask);
    end
    if (!got) begin
      $display("timeout waiting for a read ack on ports %b", mask);
      timeouts++;
    end
  endtask

  task automatic wait_write_ack();
    logic got;
    got = 1'b0;
    for (int t = 0; t < WaitLimit && !got; t++) begin
      @(negedge clk);
      got = wr_ack;
    end
    if (!got) begin
      $display("timeout waiting for a word write ack");
      timeouts++;
    end
  endtask

  // tag follows one cycle after the ack, result checked a cycle later
  task automatic read_word(input int p, input idx_t idx, input off_t off, input tag_t tag);
    @(posedge clk);
    rd_req[p] <= '{1'b1, 1'b0, idx, off};
    wait_read_ack(port_vec_t'(1) << p);
    @(posedge clk);
    rd_req[p].req <= 1'b0;
    rd_tag[p]     <= tag;
    @(posedge clk);
  endtask

  task automatic fill_line(input idx_t idx, input way_vec_t way_we, input tag_t tag,
                           input line_t data);
    @(posedge clk);
    fill <= '{1'b1, way_we, way_we, tag, idx, data};
    @(posedge clk);
    fill.vld <= 1'b0;
  endtask

  task automatic write_word(input idx_t idx, input off_t off, input way_vec_t way_we,
                            input word_t data, input be_t be);
    @(posedge clk);
    word_wr <= '{way_we, idx, off, data, be};
    wait_write_ack();
    @(posedge clk);
    word_wr.req <= '0;
  endtask

  // let the assertions of the last edge settle first
  task automatic report_test(input string name);
    int unsigned now;
    @(negedge clk);
    now = dut.u_asserts.err_cnt + timeouts;
    $display("test %s done, %0d failures", name, now - fail_mark);
    fail_mark = now;
    n_tests++;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : p_main
    logic [127:0] r;
    idx_t         idx;
    off_t         off;
    tag_t         tag;
    way_vec_t     way_we;
    line_t        line;
    be_t          be;
    int           cnt0;
    int           cnt1;
    int unsigned  n_fail;
    clk       = 1'b0;
    rst_n     = 1'b0;
    rd_req    = '0;
    rd_tag    = '0;
    fill      = '0;
    word_wr   = '0;
    lfsr_q    = 16'd73;
    timeouts  = 0;
    n_tests   = 0;
    fail_mark = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // idle outputs, then a miss on an empty cache
    repeat (4) @(posedge clk);
    random_bits(14, r);
    read_word(0, idx_t'(r), off_t'(r >> 4), tag_t'(r >> 6));
    report_test("reset_idle");

    random_bits(12, r);
    idx = idx_t'(r);
    tag = tag_t'(r >> 4);
    random_bits(1, r);
    way_we = way_vec_t'(1) << r[0];
    random_bits(128, r);
    line = r;
    fill_line(idx, way_we, tag, line);
    fill_line(idx, ~way_we, tag ^ 8'h3c, ~line);
    for (int k = 0; k < NumBanks; k++) begin
      read_word(k % NumRdPorts, idx, off_t'(k), tag);
    end
    read_word(1, idx, 2'd2, tag ^ 8'h3c);
    read_word(0, idx, 2'd1, tag ^ 8'h81);
    report_test("fill_hit");

    random_bits(38, r);
    off = off_t'(r);
    be  = be_t'(r >> 2);
    if (be == '0) begin
      be = 4'b0101;
    end
    write_word(idx, off, way_we, word_t'(r >> 6), be);
    read_word(1, idx, off, tag);
    report_test("word_write");

    // port 1 high priority over port 0
    @(posedge clk);
    rd_tag[0] <= tag;
    rd_tag[1] <= tag;
    rd_req[0] <= '{1'b1, 1'b0, idx, 2'd0};
    rd_req[1] <= '{1'b1, 1'b1, idx, 2'd1};
    wait_read_ack(2'b11);
    // equal priority after one fill cycle, a word write waits out the fill
    @(posedge clk);
    rd_req[1].prio <= 1'b0;
    fill    <= '{1'b1, 2'b01, 2'b01, tag ^ 8'hff, idx + 4'd1, line};
    word_wr <= '{way_we, idx, 2'd3, ~line[WordWidth-1:0], 4'b0110};
    @(posedge clk);
    fill.vld <= 1'b0;
    wait_write_ack();
    @(posedge clk);
    word_wr.req <= '0;
    cnt0 = 0;
    cnt1 = 0;
    for (int t = 0; t < WaitLimit && (cnt0 < 3 || cnt1 < 3); t++) begin
      @(negedge clk);
      if (rd_ack[0]) cnt0++;
      if (rd_ack[1]) cnt1++;
    end
    if (cnt0 < 3 || cnt1 < 3) begin
      $display("timeout waiting for alternating read grants");
      timeouts++;
    end
    @(posedge clk);
    rd_req <= '0;
    @(posedge clk);
    report_test("arbitration");

    // same bank as the read first, then a different bank
    random_bits(34, r);
    off = off_t'(r);
    @(posedge clk);
    rd_req[0] <= '{1'b1, 1'b0, idx, off};
    word_wr   <= '{way_we, idx, off, word_t'(r >> 2), 4'hf};
    wait_read_ack(2'b01);
    @(posedge clk);
    rd_req[0].req <= 1'b0;
    rd_tag[0]     <= tag;
    wait_write_ack();
    @(posedge clk);
    rd_req[0]   <= '{1'b1, 1'b0, idx, off};
    word_wr     <= '{way_we, idx, off + 2'd1, ~word_t'(r >> 2), 4'b1001};
    wait_write_ack();
    @(posedge clk);
    rd_req[0].req <= 1'b0;
    word_wr.req   <= '0;
    read_word(1, idx, off + 2'd1, tag);
    report_test("collision");

    repeat (4) @(posedge clk);
    n_fail = dut.u_asserts.err_cnt + timeouts;
    $display("tests run %0d, failures %0d", n_tests, n_fail);
    if (n_fail == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : p_watchdog
    #20000;
    $display("simulation stopped, the test sequence did not finish in time");
    $display("** FAIL **");
    $finish;
  end

endmodule

/* tb.f */
hdl/dcache_cfg_pkg.sv
hdl/dcache_if_pkg.sv
hdl/dcache_port_arbiter.sv
hdl/dcache_tag_lookup.sv
hdl/dcache_data_banks.sv
hdl/dcache_readout.sv
hdl/dcache_mem_top.sv
bench/dcache_mem_asserts.sv
bench/tb_dcache_mem.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dcache memory core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_dcache_mem -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_dcache_mem +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "** PASS **" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
